/* regex_cpu.f */
source/regex_pkg.sv
source/regex_fetch.sv
source/regex_exec.sv
source/regex_split_stage.sv
source/regex_cpu.sv
test/regex_cpu_sva.sv
test/regex_cpu_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the regex engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module regex_cpu_tb -f regex_cpu.f \
    -o regex_cpu_sim || exit 1
sim_out="$(./obj_dir/regex_cpu_sim 2>&1)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1

/* source/regex_cpu.sv */
// top level of the pipelined regex engine: fetch, execute and split stages
`timescale 1ns/1ns

module regex_cpu (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  logic [regex_pkg::WINDOW_CHARS*regex_pkg::CHAR_WIDTH-1:0] current_characters,
    input  logic [regex_pkg::WINDOW_CHARS-1:0]                      end_of_string,
    input  logic                                                   input_pc_valid,
    input  logic [regex_pkg::CC_ID_BITS-1:0]                        input_cc_id,
    input  logic [regex_pkg::PC_WIDTH-1:0]                          input_pc,
    output logic                                                   input_pc_ready,
    input  logic                                                   memory_ready,
    output logic [regex_pkg::MEM_ADDR_WIDTH-1:0]                    memory_addr,
    input  logic [regex_pkg::MEM_WIDTH-1:0]                         memory_data,
    output logic                                                   memory_valid,
    output logic                                                   output_pc_valid,
    output logic [regex_pkg::CC_ID_BITS-1:0]                        output_cc_id,
    output logic [regex_pkg::PC_WIDTH-1:0]                          output_pc,
    input  logic                                                   output_pc_ready,
    output logic                                                   accepts,
    output logic                                                   running
);
    import regex_pkg::*;

    // fetch to exec
    logic                   fetch_valid;
    logic [PC_WIDTH-1:0]    fetch_pc;
    logic [CC_ID_BITS-1:0]  fetch_cc_id;
    logic [INSTR_WIDTH-1:0] fetch_instr;
    logic                   exec_free;
    logic                   exec_busy;

    // exec to split stage
    logic                   split_valid;
    logic [PC_WIDTH-1:0]    split_pc;
    logic [CC_ID_BITS-1:0]  split_cc_id;
    logic [INSTR_WIDTH-1:0] split_instr;
    logic                   split_free;
    logic                   split_busy;

    // exec output into the merge
    logic                   exec_out_valid;
    logic [PC_WIDTH-1:0]    exec_out_pc;
    logic [CC_ID_BITS-1:0]  exec_out_cc_id;
    logic                   exec_out_ready;

    regex_fetch i_regex_fetch (
        .clk            (clk),
        .rst            (rst),
        .input_pc_valid (input_pc_valid),
        .input_cc_id    (input_cc_id),
        .input_pc       (input_pc),
        .input_pc_ready (input_pc_ready),
        .memory_valid   (memory_valid),
        .memory_addr    (memory_addr),
        .memory_ready   (memory_ready),
        .memory_data    (memory_data),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_cc_id    (fetch_cc_id),
        .fetch_instr    (fetch_instr),
        .exec_free      (exec_free)
    );

    regex_exec i_regex_exec (
        .clk                (clk),
        .rst                (rst),
        .current_characters (current_characters),
        .end_of_string      (end_of_string),
        .fetch_valid        (fetch_valid),
        .fetch_pc           (fetch_pc),
        .fetch_cc_id        (fetch_cc_id),
        .fetch_instr        (fetch_instr),
        .exec_free          (exec_free),
        .exec_busy          (exec_busy),
        .exec_out_valid     (exec_out_valid),
        .exec_out_pc        (exec_out_pc),
        .exec_out_cc_id     (exec_out_cc_id),
        .exec_out_ready     (exec_out_ready),
        .exec_accepts       (accepts),
        .split_valid        (split_valid),
        .split_pc           (split_pc),
        .split_cc_id        (split_cc_id),
        .split_instr        (split_instr),
        .split_free         (split_free)
    );

    regex_split_stage i_regex_split_stage (
        .clk             (clk),
        .rst             (rst),
        .split_valid     (split_valid),
        .split_pc        (split_pc),
        .split_cc_id     (split_cc_id),
        .split_instr     (split_instr),
        .split_free      (split_free),
        .split_busy      (split_busy),
        .exec_out_valid  (exec_out_valid),
        .exec_out_pc     (exec_out_pc),
        .exec_out_cc_id  (exec_out_cc_id),
        .exec_out_ready  (exec_out_ready),
        .output_pc_valid (output_pc_valid),
        .output_pc       (output_pc),
        .output_cc_id    (output_cc_id),
        .output_pc_ready (output_pc_ready)
    );

    // any stage holding a thread keeps the engine running
    assign running = fetch_valid | exec_busy | split_busy;

endmodule

/* source/regex_exec.sv */
// first execute stage: decodes the held instruction and emits the first continuation
`timescale 1ns/1ns

module regex_exec (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  logic [regex_pkg::WINDOW_CHARS*regex_pkg::CHAR_WIDTH-1:0] current_characters,
    input  logic [regex_pkg::WINDOW_CHARS-1:0]                      end_of_string,
    input  logic                                                   fetch_valid,
    input  logic [regex_pkg::PC_WIDTH-1:0]                          fetch_pc,
    input  logic [regex_pkg::CC_ID_BITS-1:0]                        fetch_cc_id,
    input  logic [regex_pkg::INSTR_WIDTH-1:0]                       fetch_instr,
    output logic                                                   exec_free,
    output logic                                                   exec_busy,
    output logic                                                   exec_out_valid,
    output logic [regex_pkg::PC_WIDTH-1:0]                          exec_out_pc,
    output logic [regex_pkg::CC_ID_BITS-1:0]                        exec_out_cc_id,
    input  logic                                                   exec_out_ready,
    output logic                                                   exec_accepts,
    output logic                                                   split_valid,
    output logic [regex_pkg::PC_WIDTH-1:0]                          split_pc,
    output logic [regex_pkg::CC_ID_BITS-1:0]                        split_cc_id,
    output logic [regex_pkg::INSTR_WIDTH-1:0]                       split_instr,
    input  logic                                                   split_free
);
    import regex_pkg::*;

    logic                    exec_valid;
    logic [PC_WIDTH-1:0]     exec_pc;
    logic [CC_ID_BITS-1:0]   exec_cc_id;
    logic [INSTR_WIDTH-1:0]  exec_instr;
    logic [OPCODE_WIDTH-1:0] opcode;
    instr_data_u             data;
    logic [CHAR_WIDTH-1:0]   cur_char;
    logic                    is_split;
    logic                    exec_move;

    assign opcode   = exec_instr[INSTR_WIDTH-1 -: OPCODE_WIDTH];
    assign data     = exec_instr[INSTR_WIDTH-OPCODE_WIDTH-1:0];
    assign cur_char = current_characters[exec_cc_id*CHAR_WIDTH +: CHAR_WIDTH];

    always_comb
    begin
        exec_out_valid = 1'b0;
        exec_out_pc    = exec_pc + 1'b1;
        exec_out_cc_id = exec_cc_id;
        exec_accepts   = 1'b0;
        is_split       = 1'b0;
        if (exec_valid)
        begin
            case (opcode)
                OP_ACCEPT:
                begin
                    exec_accepts = end_of_string[exec_cc_id];
                end
                OP_ACCEPT_PARTIAL:
                begin
                    exec_accepts = 1'b1;
                end
                OP_SPLIT:
                begin
                    // fall-through branch here, the jump goes to the split stage
                    exec_out_valid = 1'b1;
                    is_split       = 1'b1;
                end
                OP_MATCH:
                begin
                    if (cur_char == data.ch.value)
                    begin
                        exec_out_valid = 1'b1;
                        exec_out_cc_id = exec_cc_id + 1'b1;
                    end
                end
                OP_NOT_MATCH:
                begin
                    // no character consumed
                    exec_out_valid = (cur_char != data.ch.value);
                end
                OP_MATCH_ANY:
                begin
                    exec_out_valid = 1'b1;
                    exec_out_cc_id = exec_cc_id + 1'b1;
                end
                OP_JMP:
                begin
                    exec_out_valid = 1'b1;
                    exec_out_pc    = data.target;
                end
                default:
                begin
                    // END drops the thread
                end
            endcase
        end
    end

    // a split also needs room for its second branch
    assign exec_move = exec_valid & (~exec_out_valid | exec_out_ready) &
                       (~is_split | split_free);
    assign exec_free = ~exec_valid | exec_move;
    assign exec_busy = exec_valid;

    assign split_valid = exec_move & is_split;
    assign split_pc    = exec_pc;
    assign split_cc_id = exec_cc_id;
    assign split_instr = exec_instr;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            exec_valid <= 1'b0;
        end
        else if (exec_free)
        begin
            exec_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (exec_free)
        begin
            exec_pc    <= fetch_pc;
            exec_cc_id <= fetch_cc_id;
            exec_instr <= fetch_instr;
        end
    end

endmodule

/* source/regex_fetch.sv */
// fetch stage: memory request on the input handshake and capture of the returned instruction
`timescale 1ns/1ns

module regex_fetch (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                input_pc_valid,
    input  logic [regex_pkg::CC_ID_BITS-1:0]     input_cc_id,
    input  logic [regex_pkg::PC_WIDTH-1:0]       input_pc,
    output logic                                input_pc_ready,
    output logic                                memory_valid,
    output logic [regex_pkg::MEM_ADDR_WIDTH-1:0] memory_addr,
    input  logic                                memory_ready,
    input  logic [regex_pkg::MEM_WIDTH-1:0]      memory_data,
    output logic                                fetch_valid,
    output logic [regex_pkg::PC_WIDTH-1:0]       fetch_pc,
    output logic [regex_pkg::CC_ID_BITS-1:0]     fetch_cc_id,
    output logic [regex_pkg::INSTR_WIDTH-1:0]    fetch_instr,
    input  logic                                exec_free
);
    import regex_pkg::*;

    logic                   can_take;
    logic                   take;
    logic                   has_to_save;
    logic [INSTR_WIDTH-1:0] instr_q;

    // the register can take a new thread when empty or handing over this cycle
    assign can_take = ~fetch_valid | exec_free;

    assign memory_valid   = input_pc_valid & can_take;
    assign input_pc_ready = memory_valid & memory_ready;
    assign take           = input_pc_ready;

    assign memory_addr = {{(MEM_ADDR_WIDTH - PC_WIDTH){1'b0}}, input_pc};

    // memory word is only valid in the cycle after the transfer
    assign fetch_instr = has_to_save ? memory_data[INSTR_WIDTH-1:0] : instr_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            fetch_valid <= 1'b0;
            has_to_save <= 1'b0;
        end
        else
        begin
            has_to_save <= take;
            if (take)
            begin
                fetch_valid <= 1'b1;
            end
            else if (exec_free)
            begin
                fetch_valid <= 1'b0;
            end
        end
    end

    // payload of the thread waiting for exec
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            fetch_pc    <= input_pc;
            fetch_cc_id <= input_cc_id;
        end
        // keeps the captured word while exec is stalled
        instr_q <= fetch_instr;
    end

endmodule

/* source/regex_pkg.sv */
// widths, opcode codes and the instruction data union for the regex engine
package regex_pkg;

    // thread and window geometry
    localparam int PC_WIDTH     = 9;
    localparam int CC_ID_BITS   = 2;
    localparam int WINDOW_CHARS = 4;
    localparam int CHAR_WIDTH   = 8;

    // instruction memory
    localparam int MEM_ADDR_WIDTH = 11;
    localparam int MEM_WIDTH      = 16;

    // instruction word, opcode in the top bits and data below it
    localparam int OPCODE_WIDTH = 3;
    localparam int INSTR_WIDTH  = 12;

    // opcode encodings, END is zero so a cleared word does nothing
    localparam logic [OPCODE_WIDTH-1:0] OP_END            = 3'd0;
    localparam logic [OPCODE_WIDTH-1:0] OP_ACCEPT         = 3'd1;
    localparam logic [OPCODE_WIDTH-1:0] OP_ACCEPT_PARTIAL = 3'd2;
    localparam logic [OPCODE_WIDTH-1:0] OP_SPLIT          = 3'd3;
    localparam logic [OPCODE_WIDTH-1:0] OP_MATCH          = 3'd4;
    localparam logic [OPCODE_WIDTH-1:0] OP_NOT_MATCH      = 3'd5;
    localparam logic [OPCODE_WIDTH-1:0] OP_MATCH_ANY      = 3'd6;
    localparam logic [OPCODE_WIDTH-1:0] OP_JMP            = 3'd7;

    // data field of an instruction
    // jumps and splits read a target pc, character tests read a character
    typedef union packed {
        logic [PC_WIDTH-1:0] target;
        struct packed {
            logic                  pad;
            logic [CHAR_WIDTH-1:0] value;
        } ch;
    } instr_data_u;

endpackage

/* source/regex_split_stage.sv */
// second execute stage for the SPLIT jump branch and the fixed priority output merge
`timescale 1ns/1ns

module regex_split_stage (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             split_valid,
    input  logic [regex_pkg::PC_WIDTH-1:0]    split_pc,
    input  logic [regex_pkg::CC_ID_BITS-1:0]  split_cc_id,
    input  logic [regex_pkg::INSTR_WIDTH-1:0] split_instr,
    output logic                             split_free,
    output logic                             split_busy,
    input  logic                             exec_out_valid,
    input  logic [regex_pkg::PC_WIDTH-1:0]    exec_out_pc,
    input  logic [regex_pkg::CC_ID_BITS-1:0]  exec_out_cc_id,
    output logic                             exec_out_ready,
    output logic                             output_pc_valid,
    output logic [regex_pkg::PC_WIDTH-1:0]    output_pc,
    output logic [regex_pkg::CC_ID_BITS-1:0]  output_cc_id,
    input  logic                             output_pc_ready
);
    import regex_pkg::*;

    logic                  held_valid;
    logic [CC_ID_BITS-1:0] held_cc_id;
    instr_data_u           held_data;
    logic                  held_move;

    // only splits arrive here, so a held entry always offers its jump target
    assign held_move  = held_valid & output_pc_ready;
    assign split_free = ~held_valid | held_move;
    assign split_busy = held_valid;

    // held branch wins, so exec never drives the port while a branch waits
    assign exec_out_ready  = output_pc_ready & ~held_valid;
    assign output_pc_valid = held_valid | exec_out_valid;
    assign output_pc       = held_valid ? held_data.target : exec_out_pc;
    assign output_cc_id    = held_valid ? held_cc_id : exec_out_cc_id;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            held_valid <= 1'b0;
        end
        else if (split_free)
        begin
            held_valid <= split_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (split_free & split_valid)
        begin
            held_cc_id <= split_cc_id;
            held_data  <= split_instr[INSTR_WIDTH-OPCODE_WIDTH-1:0];
        end
    end

endmodule

/* test/regex_cpu_sva.sv */
// protocol assertions on the regex engine ports, bound to the top level
`timescale 1ns/1ns

module regex_cpu_sva (
    input logic                             clk,
    input logic                             rst,
    input logic                             input_pc_ready,
    input logic                             memory_valid,
    input logic                             memory_ready,
    input logic                             output_pc_valid,
    input logic                             output_pc_ready,
    input logic [regex_pkg::PC_WIDTH-1:0]   output_pc,
    input logic [regex_pkg::CC_ID_BITS-1:0] output_cc_id,
    input logic                             accepts,
    input logic                             running
);

    // an offered continuation holds until the consumer takes it
    output_held: assert property (@(posedge clk) disable iff (rst)
        (output_pc_valid && !output_pc_ready) |=>
            (output_pc_valid && $stable(output_pc) && $stable(output_cc_id)))
    else $error("output thread changed or dropped before output_pc_ready");

    // a thread is only taken while the memory request goes out
    input_ready_needs_memory: assert property (@(posedge clk)
        input_pc_ready |-> (memory_valid && memory_ready))
    else $error("input_pc_ready high without memory_valid and memory_ready");

    reset_idle: assert property (@(posedge clk)
        rst |=> (!running && !accepts && !output_pc_valid))
    else $error("engine not idle after reset");

endmodule

bind regex_cpu regex_cpu_sva i_regex_cpu_sva (
    .clk             (clk),
    .rst             (rst),
    .input_pc_ready  (input_pc_ready),
    .memory_valid    (memory_valid),
    .memory_ready    (memory_ready),
    .output_pc_valid (output_pc_valid),
    .output_pc_ready (output_pc_ready),
    .output_pc       (output_pc),
    .output_cc_id    (output_cc_id),
    .accepts         (accepts),
    .running         (running)
);

/* test/regex_cpu_tb.sv */
// testbench for the regex engine: clock, reset, ROM model, random stimulus, reference queue, watchdog
`timescale 1ns/1ns

module regex_cpu_tb;
    import regex_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_THREADS = 200;
    localparam int WATCHDOG_NS = NUM_THREADS * 40 * CLK_PERIOD;

    logic                                 clk;
    logic                                 rst;
    logic [WINDOW_CHARS*CHAR_WIDTH-1:0]   current_characters;
    logic [WINDOW_CHARS-1:0]              end_of_string;
    logic                                 input_pc_valid;
    logic [CC_ID_BITS-1:0]                input_cc_id;
    logic [PC_WIDTH-1:0]                  input_pc;
    logic                                 input_pc_ready;
    logic                                 memory_ready;
    logic [MEM_ADDR_WIDTH-1:0]            memory_addr;
    logic [MEM_WIDTH-1:0]                 memory_data;
    logic                                 memory_valid;
    logic                                 output_pc_valid;
    logic [CC_ID_BITS-1:0]                output_cc_id;
    logic [PC_WIDTH-1:0]                  output_pc;
    logic                                 output_pc_ready;
    logic                                 accepts;
    logic                                 running;

    logic [MEM_WIDTH-1:0]                 rom [0:(1 << MEM_ADDR_WIDTH)-1];
    logic [CHAR_WIDTH-1:0]                window [WINDOW_CHARS];
    logic [PC_WIDTH+CC_ID_BITS-1:0]       exp_q [$];
    int                                   accept_pending;
    int                                   sent;
    logic [31:0]                          rng;
    logic                                 xfer_prev;
    logic [MEM_ADDR_WIDTH-1:0]            addr_prev;

    regex_cpu i_regex_cpu (
        .clk                (clk),
        .rst                (rst),
        .current_characters (current_characters),
        .end_of_string      (end_of_string),
        .input_pc_valid     (input_pc_valid),
        .input_cc_id        (input_cc_id),
        .input_pc           (input_pc),
        .input_pc_ready     (input_pc_ready),
        .memory_ready       (memory_ready),
        .memory_addr        (memory_addr),
        .memory_data        (memory_data),
        .memory_valid       (memory_valid),
        .output_pc_valid    (output_pc_valid),
        .output_cc_id       (output_cc_id),
        .output_pc          (output_pc),
        .output_pc_ready    (output_pc_ready),
        .accepts            (accepts),
        .running            (running)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [MEM_WIDTH-1:0] make_word(input logic [OPCODE_WIDTH-1:0] op,
                                                       input logic [PC_WIDTH-1:0] field);
        return MEM_WIDTH'({op, field});
    endfunction

    function automatic logic [PC_WIDTH-1:0] char_field(input logic [CHAR_WIDTH-1:0] c);
        instr_data_u d;
        d.ch.pad   = 1'b0;
        d.ch.value = c;
        return d;
    endfunction

    task automatic load_program();
        // unused words follow their own address
        for (int a = 0; a < (1 << MEM_ADDR_WIDTH); a++)
        begin
            rom[a] = MEM_WIDTH'(a * 37);
        end
        rom[0]  = make_word(OP_MATCH, char_field("a"));
        rom[1]  = make_word(OP_MATCH, char_field("c"));
        rom[2]  = make_word(OP_NOT_MATCH, char_field("b"));
        rom[3]  = make_word(OP_NOT_MATCH, char_field("d"));
        rom[4]  = make_word(OP_MATCH_ANY, '0);
        rom[5]  = make_word(OP_JMP, 9'd9);
        rom[6]  = make_word(OP_SPLIT, 9'd12);
        rom[7]  = make_word(OP_ACCEPT, '0);
        rom[8]  = make_word(OP_ACCEPT_PARTIAL, '0);
        rom[9]  = make_word(OP_END, '0);
        rom[10] = make_word(OP_SPLIT, 9'd3);
        rom[11] = make_word(OP_JMP, 9'd0);
        rom[12] = make_word(OP_MATCH, char_field("d"));
        rom[13] = make_word(OP_ACCEPT, '0);
        rom[14] = make_word(OP_NOT_MATCH, char_field("a"));
        rom[15] = make_word(OP_MATCH_ANY, '0);
    endtask

    task automatic fail_check(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // continuations and accept pulse that one thread must produce
    task automatic expect_thread(input logic [PC_WIDTH-1:0] pc, input logic [CC_ID_BITS-1:0] cc);
        logic [MEM_WIDTH-1:0]    word;
        logic [OPCODE_WIDTH-1:0] op;
        instr_data_u             data;
        logic [PC_WIDTH-1:0]     next_pc;
        logic [CC_ID_BITS-1:0]   next_cc;
        word    = rom[MEM_ADDR_WIDTH'(pc)];
        op      = word[INSTR_WIDTH-1 -: OPCODE_WIDTH];
        data    = word[INSTR_WIDTH-OPCODE_WIDTH-1:0];
        next_pc = PC_WIDTH'(pc + 1);
        next_cc = CC_ID_BITS'(cc + 1);
        case (op)
            OP_ACCEPT:
            begin
                if (end_of_string[cc])
                begin
                    accept_pending++;
                end
            end
            OP_ACCEPT_PARTIAL:
            begin
                accept_pending++;
            end
            OP_SPLIT:
            begin
                // fall-through branch first, jump branch right behind it
                exp_q.push_back({next_pc, cc});
                exp_q.push_back({data.target, cc});
            end
            OP_MATCH:
            begin
                if (window[cc] == data.ch.value)
                begin
                    exp_q.push_back({next_pc, next_cc});
                end
            end
            OP_NOT_MATCH:
            begin
                if (window[cc] != data.ch.value)
                begin
                    exp_q.push_back({next_pc, cc});
                end
            end
            OP_MATCH_ANY:
            begin
                exp_q.push_back({next_pc, next_cc});
            end
            OP_JMP:
            begin
                exp_q.push_back({data.target, cc});
            end
            default:
            begin
                // END drops the thread
            end
        endcase
    endtask

    task automatic run_cycle();
        logic                  xfer;
        logic [PC_WIDTH-1:0]   exp_pc;
        logic [CC_ID_BITS-1:0] exp_cc;
        @(negedge clk);
        // word for the thread taken at the last rising edge
        if (xfer_prev)
        begin
            memory_data    = rom[addr_prev];
            input_pc_valid = 1'b0;
        end
        rng             = xorshift(rng);
        memory_ready    = rng[0] | rng[1];
        output_pc_ready = rng[2] | rng[3];
        if (!input_pc_valid && sent < NUM_THREADS && (rng[4] | rng[5]))
        begin
            input_pc_valid = 1'b1;
            input_pc       = PC_WIDTH'(rng[11:8]);
            input_cc_id    = rng[13:12];
        end
        #1;
        if (memory_valid)
        begin
            assert (memory_addr == MEM_ADDR_WIDTH'(input_pc))
            else fail_check($sformatf("memory address %0d for thread pc %0d", memory_addr, input_pc));
        end
        xfer = input_pc_valid & input_pc_ready;
        if (xfer)
        begin
            addr_prev = memory_addr;
            expect_thread(input_pc, input_cc_id);
            sent++;
        end
        xfer_prev = xfer;
        if (output_pc_valid && output_pc_ready)
        begin
            assert (exp_q.size() != 0)
            else fail_check($sformatf("unexpected output pc %0d cc %0d", output_pc, output_cc_id));
            {exp_pc, exp_cc} = exp_q.pop_front();
            assert (output_pc == exp_pc && output_cc_id == exp_cc)
            else fail_check($sformatf("output pc %0d cc %0d, expected pc %0d cc %0d",
                                      output_pc, output_cc_id, exp_pc, exp_cc));
        end
        if (accepts)
        begin
            assert (accept_pending > 0)
            else fail_check("accepts pulsed with no accepting thread due");
            accept_pending--;
        end
    endtask

    initial
    begin
        int drain_cycles;
        rst                = 1'b1;
        window[0]          = "a";
        window[1]          = "b";
        window[2]          = "c";
        window[3]          = "d";
        current_characters = {window[3], window[2], window[1], window[0]};
        end_of_string      = 4'b0100;
        input_pc_valid     = 1'b0;
        input_cc_id        = '0;
        input_pc           = '0;
        memory_ready       = 1'b0;
        memory_data        = '0;
        output_pc_ready    = 1'b0;
        rng                = 32'd60;
        sent               = 0;
        accept_pending     = 0;
        xfer_prev          = 1'b0;
        addr_prev          = '0;
        load_program();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        assert (!running && !accepts && !output_pc_valid && !memory_valid && !input_pc_ready)
        else fail_check("engine not idle after reset");
        while (sent < NUM_THREADS || exp_q.size() != 0 || accept_pending != 0)
        begin
            run_cycle();
        end
        // threads that end without output may still sit in the pipeline
        drain_cycles = 0;
        while ((running || xfer_prev) && drain_cycles < 8)
        begin
            run_cycle();
            drain_cycles++;
        end
        if (!running)
        begin
            $display("TESTBENCH PASSED");
            $finish;
        end
        else
        begin
            $display("running stayed high after every thread had drained");
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: threads still in flight after %0d cycles", NUM_THREADS * 40);
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

endmodule
